//--- Bender.yml
package:
  name: div_accel

sources:
  - files:
      - hdl/div_pkg.sv
      - hdl/divider_array_triangular.sv
      - hdl/div_lane.sv
      - hdl/job_dispatch.sv
      - hdl/result_arbiter.sv
      - hdl/div_accel_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_div_accel.sv

//--- filelist.f
+incdir+testbench
hdl/div_pkg.sv
hdl/divider_array_triangular.sv
hdl/div_lane.sv
hdl/job_dispatch.sv
hdl/result_arbiter.sv
hdl/div_accel_top.sv
testbench/tb_div_accel.sv

//--- hdl/div_accel_top.sv
`timescale 1ns/10ps
`default_nettype none

module div_accel_top (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              job_valid,
  input  wire  div_pkg::div_op_e           job_op,
  input  wire  [div_pkg::dividend_w-1:0]   job_n,
  input  wire  [div_pkg::divisor_w-1:0]    job_d,
  input  wire  [div_pkg::tag_w-1:0]        job_tag,
  output logic                             job_credit,
  output logic                             res_valid,
  output logic [div_pkg::divisor_w-1:0]    res_q,
  output logic [div_pkg::divisor_w-1:0]    res_r,
  output logic [div_pkg::tag_w-1:0]        res_tag,
  output div_pkg::div_op_e                 res_op,
  input  wire                              res_credit
);

  // dispatcher to lanes
  wire                            exact_valid;
  wire                            approx_valid;
  wire [div_pkg::dividend_w-1:0]  lane_n;
  wire [div_pkg::divisor_w-1:0]   lane_d;
  wire [div_pkg::tag_w-1:0]       lane_tag;
  wire                            exact_ready;
  wire                            approx_ready;

  // lanes to arbiter
  wire                            exact_done;
  wire [div_pkg::divisor_w-1:0]   exact_q;
  wire [div_pkg::divisor_w-1:0]   exact_r;
  wire [div_pkg::tag_w-1:0]       exact_tag;
  wire                            exact_grant;
  wire                            approx_done;
  wire [div_pkg::divisor_w-1:0]   approx_q;
  wire [div_pkg::divisor_w-1:0]   approx_r;
  wire [div_pkg::tag_w-1:0]       approx_tag;
  wire                            approx_grant;

  job_dispatch u_job_dispatch (
    .clk(clk), .rst(rst),
    .job_valid(job_valid), .job_op(job_op), .job_n(job_n), .job_d(job_d),
    .job_tag(job_tag), .job_credit(job_credit),
    .exact_valid(exact_valid), .approx_valid(approx_valid),
    .lane_n(lane_n), .lane_d(lane_d), .lane_tag(lane_tag),
    .exact_ready(exact_ready), .approx_ready(approx_ready)
  );

  div_lane #(.approx_depth(0)) u_lane_exact (
    .clk(clk), .rst(rst),
    .lane_valid(exact_valid), .lane_n(lane_n), .lane_d(lane_d), .lane_tag(lane_tag),
    .lane_ready(exact_ready), .done_valid(exact_done), .done_q(exact_q),
    .done_r(exact_r), .done_tag(exact_tag), .grant(exact_grant)
  );

  div_lane #(.approx_depth(div_pkg::approx_depth_lane)) u_lane_approx (
    .clk(clk), .rst(rst),
    .lane_valid(approx_valid), .lane_n(lane_n), .lane_d(lane_d), .lane_tag(lane_tag),
    .lane_ready(approx_ready), .done_valid(approx_done), .done_q(approx_q),
    .done_r(approx_r), .done_tag(approx_tag), .grant(approx_grant)
  );

  result_arbiter u_result_arbiter (
    .clk(clk), .rst(rst),
    .exact_done(exact_done), .exact_q(exact_q), .exact_r(exact_r), .exact_tag(exact_tag),
    .approx_done(approx_done), .approx_q(approx_q), .approx_r(approx_r),
    .approx_tag(approx_tag),
    .exact_grant(exact_grant), .approx_grant(approx_grant),
    .res_valid(res_valid), .res_q(res_q), .res_r(res_r), .res_tag(res_tag),
    .res_op(res_op), .res_credit(res_credit)
  );

endmodule

`default_nettype wire

//--- hdl/div_lane.sv
`timescale 1ns/10ps
`default_nettype none

// one division lane, a single job slot in front of the array
module div_lane #(
  parameter int approx_depth = 0
) (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              lane_valid,
  input  wire  [div_pkg::dividend_w-1:0]   lane_n,
  input  wire  [div_pkg::divisor_w-1:0]    lane_d,
  input  wire  [div_pkg::tag_w-1:0]        lane_tag,
  output logic                             lane_ready,
  output logic                             done_valid,
  output logic [div_pkg::divisor_w-1:0]    done_q,
  output logic [div_pkg::divisor_w-1:0]    done_r,
  output logic [div_pkg::tag_w-1:0]        done_tag,
  input  wire                              grant
);

  div_pkg::lane_state_e state;

  logic [div_pkg::dividend_w-1:0] n_reg;
  logic [div_pkg::divisor_w-1:0]  d_reg;
  wire  [div_pkg::divisor_w-1:0]  q_arr;
  wire  [div_pkg::divisor_w-1:0]  r_arr;

  divider_array_triangular #(
    .approx_depth(approx_depth)
  ) u_array (
    .n(n_reg),
    .d(d_reg),
    .q(q_arr),
    .r(r_arr)
  );

  assign lane_ready = (state == div_pkg::lane_idle);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= div_pkg::lane_idle;
      done_valid <= 1'b0;
    end else begin
      case (state)
        div_pkg::lane_idle: if (lane_valid) state <= div_pkg::lane_full;
        div_pkg::lane_full: begin
          if (!done_valid) begin
            done_valid <= 1'b1;  // array settled on captured operands
          end else if (grant) begin
            done_valid <= 1'b0;
            state      <= div_pkg::lane_idle;
          end
        end
        default: state <= div_pkg::lane_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (lane_ready && lane_valid) begin
      n_reg    <= lane_n;
      d_reg    <= lane_d;
      done_tag <= lane_tag;
    end
    if (state == div_pkg::lane_full && !done_valid) begin
      done_q <= q_arr;
      done_r <= r_arr;
    end
  end

endmodule

`default_nettype wire

//--- hdl/div_pkg.sv
`default_nettype none

package div_pkg;

  // operand and result widths
  localparam int dividend_w = 16;
  localparam int divisor_w  = 8;  // also quotient and remainder
  localparam int tag_w      = 4;

  // job queue, host starts with one credit per entry
  localparam int job_queue_depth = 4;
  localparam int queue_ptr_w     = $clog2(job_queue_depth);
  localparam int queue_cnt_w     = $clog2(job_queue_depth + 1);
  localparam logic [queue_ptr_w-1:0] queue_last = queue_ptr_w'(job_queue_depth - 1);

  // result bus credits held by the arbiter out of reset
  localparam int res_credit_init = 2;
  localparam int res_credit_w    = $clog2(res_credit_init + 1);
  localparam logic [res_credit_w-1:0] res_credit_reset = res_credit_w'(res_credit_init);

  // corner cells replaced in the approximate lane
  localparam int approx_depth_lane = 2;

  // job opcode, also the lane index on the result bus
  typedef enum logic {
    op_exact  = 1'b0,
    op_approx = 1'b1
  } div_op_e;

  typedef enum logic {
    lane_idle = 1'b0,
    lane_full = 1'b1
  } lane_state_e;

endpackage

`default_nettype wire

//--- hdl/divider_array_triangular.sv
`timescale 1ns/10ps
`default_nettype none

// restoring divider built from a triangular grid of borrow cells
// row i resolves quotient bit i, row 7 sits on the dividend top bits
module divider_array_triangular #(
  parameter int approx_depth = 0
) (
  input  wire  [div_pkg::dividend_w-1:0] n,
  input  wire  [div_pkg::divisor_w-1:0]  d,
  output logic [div_pkg::divisor_w-1:0]  q,
  output logic [div_pkg::divisor_w-1:0]  r
);

  localparam int rows = div_pkg::divisor_w;
  localparam int cols = div_pkg::divisor_w;

  wire [cols-1:0] r_loc [0:rows-1];  // partial remainder out of each cell
  wire [cols-1:0] b_loc [0:rows-1];  // borrow chain per row
  wire [rows-1:0] q_int;

  for (genvar i = 0; i < rows; i++) begin : g_row
    for (genvar j = 0; j < cols; j++) begin : g_col
      wire cell_x;
      wire cell_bin;
      wire cell_diff;

      // minuend bit and borrow in
      if (j == 0) begin : g_lsb
        assign cell_x   = n[i];
        assign cell_bin = 1'b0;
      end else if (i == rows - 1) begin : g_top
        assign cell_x   = n[i+j];
        assign cell_bin = b_loc[i][j-1];
      end else begin : g_mid
        assign cell_x   = r_loc[i+1][j-1];  // shifted remainder from row above
        assign cell_bin = b_loc[i][j-1];
      end

      if (i + j < approx_depth) begin : g_apx
        // approximate corner cell, no borrow out
        assign cell_diff   = cell_x & ~cell_bin;
        assign b_loc[i][j] = 1'b0;
      end else begin : g_ext
        assign cell_diff   = cell_x ^ d[j] ^ cell_bin;
        assign b_loc[i][j] = (~cell_x & d[j]) | (~(cell_x ^ d[j]) & cell_bin);
      end

      // restore unless the row subtraction succeeded
      assign r_loc[i][j] = q_int[i] ? cell_diff : cell_x;
    end

    if (i == rows - 1) begin : g_q_top
      assign q_int[i] = n[div_pkg::dividend_w-1] | ~b_loc[i][cols-1];
    end else begin : g_q_mid
      // bit shifted out of the row above forces a successful subtract
      assign q_int[i] = r_loc[i+1][cols-1] | ~b_loc[i][cols-1];
    end
  end

  assign q = q_int;
  assign r = r_loc[0];

endmodule

`default_nettype wire

//--- hdl/job_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

// credit controlled job queue, head goes to the lane named by its opcode
module job_dispatch (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              job_valid,
  input  wire  div_pkg::div_op_e           job_op,
  input  wire  [div_pkg::dividend_w-1:0]   job_n,
  input  wire  [div_pkg::divisor_w-1:0]    job_d,
  input  wire  [div_pkg::tag_w-1:0]        job_tag,
  output logic                             job_credit,
  output logic                             exact_valid,
  output logic                             approx_valid,
  output logic [div_pkg::dividend_w-1:0]   lane_n,
  output logic [div_pkg::divisor_w-1:0]    lane_d,
  output logic [div_pkg::tag_w-1:0]        lane_tag,
  input  wire                              exact_ready,
  input  wire                              approx_ready
);

  div_pkg::div_op_e               q_op  [div_pkg::job_queue_depth];
  logic [div_pkg::dividend_w-1:0] q_n   [div_pkg::job_queue_depth];
  logic [div_pkg::divisor_w-1:0]  q_d   [div_pkg::job_queue_depth];
  logic [div_pkg::tag_w-1:0]      q_tag [div_pkg::job_queue_depth];

  logic [div_pkg::queue_ptr_w-1:0] wr_ptr;
  logic [div_pkg::queue_ptr_w-1:0] rd_ptr;
  logic [div_pkg::queue_cnt_w-1:0] count;

  logic not_empty;
  logic push;
  logic pop;

  assign not_empty = (count != '0);
  assign push      = job_valid;  // host never sends without a credit

  // head waits for its own lane, blocking everything behind it
  assign exact_valid  = not_empty && (q_op[rd_ptr] == div_pkg::op_exact) && exact_ready;
  assign approx_valid = not_empty && (q_op[rd_ptr] == div_pkg::op_approx) && approx_ready;
  assign pop          = exact_valid | approx_valid;

  // operands shared, at most one lane valid per cycle
  assign lane_n   = q_n[rd_ptr];
  assign lane_d   = q_d[rd_ptr];
  assign lane_tag = q_tag[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      q_op[wr_ptr]  <= job_op;
      q_n[wr_ptr]   <= job_n;
      q_d[wr_ptr]   <= job_d;
      q_tag[wr_ptr] <= job_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      job_credit <= 1'b0;
    end else begin
      job_credit <= pop;  // one credit back per entry leaving
      if (push) begin
        wr_ptr <= (wr_ptr == div_pkg::queue_last) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == div_pkg::queue_last) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/result_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

// round robin of the two lanes onto the credit controlled result bus
module result_arbiter (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              exact_done,
  input  wire  [div_pkg::divisor_w-1:0]    exact_q,
  input  wire  [div_pkg::divisor_w-1:0]    exact_r,
  input  wire  [div_pkg::tag_w-1:0]        exact_tag,
  input  wire                              approx_done,
  input  wire  [div_pkg::divisor_w-1:0]    approx_q,
  input  wire  [div_pkg::divisor_w-1:0]    approx_r,
  input  wire  [div_pkg::tag_w-1:0]        approx_tag,
  output logic                             exact_grant,
  output logic                             approx_grant,
  output logic                             res_valid,
  output logic [div_pkg::divisor_w-1:0]    res_q,
  output logic [div_pkg::divisor_w-1:0]    res_r,
  output logic [div_pkg::tag_w-1:0]        res_tag,
  output div_pkg::div_op_e                 res_op,
  input  wire                              res_credit
);

  logic [div_pkg::res_credit_w-1:0] credits;
  div_pkg::div_op_e last_served;

  logic has_credit;
  logic pick_approx;
  logic issue;

  assign has_credit = (credits != '0);

  // approx wins if alone, or on a tie when exact went last
  assign pick_approx = approx_done && (!exact_done || last_served == div_pkg::op_exact);

  assign approx_grant = has_credit && pick_approx;
  assign exact_grant  = has_credit && exact_done && !pick_approx;
  assign issue        = exact_grant | approx_grant;

  always_ff @(posedge clk) begin
    if (rst) begin
      credits     <= div_pkg::res_credit_reset;
      last_served <= div_pkg::op_approx;  // exact first on the first tie
      res_valid   <= 1'b0;
    end else begin
      res_valid <= issue;
      if (issue) last_served <= approx_grant ? div_pkg::op_approx : div_pkg::op_exact;
      case ({issue, res_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      res_q   <= approx_grant ? approx_q : exact_q;
      res_r   <= approx_grant ? approx_r : exact_r;
      res_tag <= approx_grant ? approx_tag : exact_tag;
      res_op  <= approx_grant ? div_pkg::op_approx : div_pkg::op_exact;
    end
  end

endmodule

`default_nettype wire

//--- testbench/div_ref_model.svh
`ifndef div_ref_model_svh
`define div_ref_model_svh

// 16-bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
  logic feedback;
  feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
  return {state[14:0], feedback};
endfunction

// bit level model of the triangular array, returns {quotient, remainder}
// row i produces quotient bit i, rows evaluated top down
function automatic logic [15:0] array_divide(
  input logic [div_pkg::dividend_w-1:0] n,
  input logic [div_pkg::divisor_w-1:0]  d,
  input int                             depth
);
  logic [div_pkg::divisor_w-1:0] x;
  logic [div_pkg::divisor_w-1:0] diff;
  logic [div_pkg::divisor_w-1:0] rem;
  logic [div_pkg::divisor_w-1:0] q;
  logic borrow;
  logic borrow_out;
  logic top;
  rem = '0;
  q   = '0;
  for (int i = div_pkg::divisor_w - 1; i >= 0; i--) begin
    borrow = 1'b0;
    for (int j = 0; j < div_pkg::divisor_w; j++) begin
      if (j == 0) begin
        x[j] = n[i];
      end else if (i == div_pkg::divisor_w - 1) begin
        x[j] = n[i+j];  // top row reads the dividend directly
      end else begin
        x[j] = rem[j-1];
      end
      if (i + j < depth) begin
        diff[j]    = x[j] & ~borrow;  // corner cell never borrows
        borrow_out = 1'b0;
      end else begin
        diff[j]    = x[j] ^ d[j] ^ borrow;
        borrow_out = (~x[j] & d[j]) | (~x[j] & borrow) | (d[j] & borrow);
      end
      borrow = borrow_out;
    end
    top  = (i == div_pkg::divisor_w - 1) ? n[div_pkg::dividend_w-1] : rem[div_pkg::divisor_w-1];
    q[i] = top | ~borrow;
    rem  = q[i] ? diff : x;
  end
  return {q, rem};
endfunction

`endif

//--- testbench/tb_div_accel.sv
`timescale 1ns/10ps
`default_nettype none

module tb_div_accel;

  localparam int timeout_cycles = 300;
  localparam int tag_count      = 2 ** div_pkg::tag_w;

  logic                           clk;
  logic                           rst;
  logic                           job_valid;
  div_pkg::div_op_e               job_op;
  logic [div_pkg::dividend_w-1:0] job_n;
  logic [div_pkg::divisor_w-1:0]  job_d;
  logic [div_pkg::tag_w-1:0]      job_tag;
  logic                           res_credit;
  wire                            job_credit;
  wire                            res_valid;
  wire  [div_pkg::divisor_w-1:0]  res_q;
  wire  [div_pkg::divisor_w-1:0]  res_r;
  wire  [div_pkg::tag_w-1:0]      res_tag;
  div_pkg::div_op_e               res_op;

  // scoreboard indexed by tag
  bit                            pending [tag_count];
  logic [div_pkg::divisor_w-1:0] exp_q   [tag_count];
  logic [div_pkg::divisor_w-1:0] exp_r   [tag_count];
  div_pkg::div_op_e              exp_op  [tag_count];
  div_pkg::div_op_e              op_log  [$];
  int                            issue_cycle [$];

  int          errors;
  int          checks;
  int          host_credits;
  int          min_credits;
  int          credit_pulses;
  int          results_seen;
  int          owed_credits;  // result credits not yet handed back
  int          outstanding;
  int          cycle_count;
  bit          hold_credits;
  logic [15:0] lfsr_state;

  `include "div_ref_model.svh"

  div_accel_top u_div_accel_top (
    .clk(clk), .rst(rst),
    .job_valid(job_valid), .job_op(job_op), .job_n(job_n), .job_d(job_d),
    .job_tag(job_tag), .job_credit(job_credit),
    .res_valid(res_valid), .res_q(res_q), .res_r(res_r), .res_tag(res_tag),
    .res_op(res_op), .res_credit(res_credit)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [15:0] random_bits(input int width);
    logic [15:0] value;
    value = '0;
    for (int b = 0; b < width; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[14:0], lfsr_state[0]};
    end
    return value;
  endfunction

  task automatic expect_true(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      $display("Fail at %0d ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic check_result();
    bit known;
    known = pending[res_tag];
    expect_true(known, $sformatf("result tag %0d was not expected", res_tag));
    if (known) begin
      expect_true(res_q == exp_q[res_tag], $sformatf("tag %0d quotient %0d, expected %0d",
                                                     res_tag, res_q, exp_q[res_tag]));
      expect_true(res_r == exp_r[res_tag], $sformatf("tag %0d remainder %0d, expected %0d",
                                                     res_tag, res_r, exp_r[res_tag]));
      expect_true(res_op == exp_op[res_tag], $sformatf("tag %0d came from lane %0d",
                                                       res_tag, res_op));
      pending[res_tag] = 1'b0;
      outstanding--;
    end
    results_seen++;
    owed_credits++;
    op_log.push_back(res_op);
    issue_cycle.push_back(cycle_count);
  endtask

  // outputs sampled mid cycle and inputs driven right after
  task automatic step_cycle();
    @(negedge clk);
    cycle_count++;
    if (job_credit) begin
      host_credits++;
      credit_pulses++;
    end
    if (res_valid) check_result();
    job_valid  = 1'b0;
    res_credit = 1'b0;
    if (!hold_credits && owed_credits > 0) begin
      res_credit = 1'b1;
      owed_credits--;
    end
  endtask

  task automatic send_job(input div_pkg::div_op_e op, input logic [15:0] n,
                          input logic [7:0] d, input logic [3:0] tag);
    logic [15:0] model;
    int          waited;
    model  = array_divide(n, d, (op == div_pkg::op_approx) ? div_pkg::approx_depth_lane : 0);
    waited = 0;
    step_cycle();
    while (host_credits == 0 && waited < timeout_cycles) begin
      step_cycle();
      waited++;
    end
    if (host_credits == 0) begin
      $display("No job credit came back in time, so the job with tag %0d was never sent", tag);
      errors++;
    end else begin
      job_valid = 1'b1;
      job_op    = op;
      job_n     = n;
      job_d     = d;
      job_tag   = tag;
      host_credits--;
      if (host_credits < min_credits) min_credits = host_credits;
      pending[tag] = 1'b1;
      exp_q[tag]   = model[15:8];
      exp_r[tag]   = model[7:0];
      exp_op[tag]  = op;
      outstanding++;
    end
  endtask

  task automatic report_missing();
    for (int t = 0; t < tag_count; t++) begin
      if (pending[t]) begin
        $display("Timed out: the result for tag %0d never arrived", t);
        errors++;
        pending[t] = 1'b0;
      end
    end
    outstanding = 0;
  endtask

  task automatic wait_for_results();
    int waited;
    waited = 0;
    while ((outstanding > 0 || owed_credits > 0) && waited < timeout_cycles) begin
      step_cycle();
      waited++;
    end
    if (outstanding > 0) report_missing();
  endtask

  task automatic finish_test(input string name, input int start);
    $display("%-16s %0d errors", name, errors - start);
  endtask

  task automatic test_reset_state();
    int start;
    start = errors;
    repeat (6) begin
      step_cycle();
      expect_true(!res_valid && !job_credit, "result or credit active with no jobs sent");
    end
    expect_true(host_credits == div_pkg::job_queue_depth, "host credit count off after reset");
    finish_test("reset_state", start);
  endtask

  task automatic test_exact_lane();
    logic [15:0] n_list [6];
    logic [7:0]  d_list [6];
    logic [15:0] model;
    int          start;
    start  = errors;
    n_list = '{1000, 12345, 65279, 255, 0, 40000};
    d_list = '{7, 100, 255, 1, 9, 200};  // every n below d shifted by 8
    for (int k = 0; k < 6; k++) begin
      model = array_divide(n_list[k], d_list[k], 0);
      expect_true(model == {8'(n_list[k] / d_list[k]), 8'(n_list[k] % d_list[k])},
                  $sformatf("model disagrees with %0d / %0d", n_list[k], d_list[k]));
      send_job(div_pkg::op_exact, n_list[k], d_list[k], 4'(k));
    end
    wait_for_results();
    finish_test("exact_lane", start);
  endtask

  task automatic test_approx_lane();
    logic [15:0] n_list [6];
    logic [7:0]  d_list [6];
    int          differ;
    int          start;
    start  = errors;
    differ = 0;
    n_list = '{1001, 45, 255, 5000, 77, 300};
    d_list = '{7, 3, 5, 97, 11, 3};
    for (int k = 0; k < 6; k++) begin
      if (array_divide(n_list[k], d_list[k], div_pkg::approx_depth_lane) !=
          array_divide(n_list[k], d_list[k], 0)) differ++;
      send_job(div_pkg::op_approx, n_list[k], d_list[k], 4'(k + 6));
    end
    expect_true(differ > 0, "no chosen operand exercises the corner cells");
    wait_for_results();
    finish_test("approx_lane", start);
  endtask

  task automatic test_mixed_random();
    logic [15:0] bits;
    logic [3:0]  tag;
    int          base;
    int          start;
    start       = errors;
    base        = results_seen;
    min_credits = host_credits;
    for (int k = 0; k < 12; k++) begin
      bits = random_bits(1);
      tag  = 4'(random_bits(4));
      while (pending[tag]) tag++;  // next free tag
      send_job(div_pkg::div_op_e'(bits[0]), random_bits(16), 8'(random_bits(8)), tag);
    end
    wait_for_results();
    expect_true(results_seen - base == 12, "result count differs from jobs sent");
    expect_true(min_credits == 0, "host never ran out of job credits");
    finish_test("mixed_random", start);
  endtask

  task automatic test_back_pressure();
    int base;
    int pulses;
    int start;
    start        = errors;
    base         = results_seen;
    hold_credits = 1'b1;
    // two issued, two held in lanes, four queued
    for (int k = 0; k < 8; k++) begin
      send_job(k[0] ? div_pkg::op_approx : div_pkg::op_exact, 16'(500 + 37 * k),
               8'(3 + 2 * k), 4'(k));
    end
    pulses = credit_pulses;
    repeat (20) step_cycle();
    expect_true(results_seen - base == div_pkg::res_credit_init,
                "results issued without result credits");
    expect_true(credit_pulses == pulses, "job credits returned with the queue stalled");
    expect_true(host_credits == 0, "host kept job credits with the queue full");
    hold_credits = 1'b0;
    wait_for_results();
    expect_true(results_seen - base == 8, "results lost under back-pressure");
    expect_true(host_credits == div_pkg::job_queue_depth, "job credits not all returned");
    finish_test("back_pressure", start);
  endtask

  task automatic test_fair_arbitration();
    int base;
    int pulses;
    int waited;
    int start;
    start        = errors;
    base         = results_seen;
    pulses       = credit_pulses;
    waited       = 0;
    hold_credits = 1'b1;
    op_log.delete();
    issue_cycle.delete();
    send_job(div_pkg::op_exact, 900, 7, 0);   // these two use up the result credits
    send_job(div_pkg::op_approx, 900, 7, 1);
    send_job(div_pkg::op_exact, 4321, 13, 2);
    send_job(div_pkg::op_approx, 4321, 13, 3);
    while ((credit_pulses - pulses < 4 || results_seen - base < 2) && waited < timeout_cycles) begin
      step_cycle();
      waited++;
    end
    if (credit_pulses - pulses < 4 || results_seen - base < 2) begin
      $display("The lanes were never both loaded before the timeout");
      errors++;
    end
    repeat (3) step_cycle();  // lane result valid one edge after capture
    hold_credits = 1'b0;
    wait_for_results();
    expect_true(op_log.size() == 4, "wrong number of results in arbitration test");
    if (op_log.size() == 4) begin
      expect_true(op_log[2] != op_log[1], "waiting lanes not served alternately");
      expect_true(issue_cycle[3] == issue_cycle[2] + 1,
                  "waiting lanes not issued in consecutive cycles");
    end
    finish_test("fair_arbitration", start);
  endtask

  initial begin
    rst           = 1'b1;
    job_valid     = 1'b0;
    job_op        = div_pkg::op_exact;
    job_n         = '0;
    job_d         = '0;
    job_tag       = '0;
    res_credit    = 1'b0;
    errors        = 0;
    checks        = 0;
    host_credits  = div_pkg::job_queue_depth;
    min_credits   = host_credits;
    credit_pulses = 0;
    results_seen  = 0;
    owed_credits  = 0;
    outstanding   = 0;
    cycle_count   = 0;
    hold_credits  = 1'b0;
    lfsr_state    = 16'd72;
    for (int t = 0; t < tag_count; t++) pending[t] = 1'b0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    test_reset_state();
    test_exact_lane();
    test_approx_lane();
    test_mixed_random();
    test_back_pressure();
    test_fair_arbitration();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
